/* decode_pkg.sv */
// Shared types and encodings for the RV32I decode stage
// Functional unit bits, micro-op codes, opcodes, operand sources
// and trap causes
package decode_pkg;

    typedef logic [31:0] word_t;     // Data, address or instruction word
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  uop_t;
    typedef logic [4:0]  fu_t;       // One-hot unit select
    typedef logic [6:0]  opr_src_t;  // One source bit per operand choice
    typedef logic [2:0]  imm_fmt_t;

    // --------------------
    // Functional unit bit positions, bits 3 and 4 reserved
    localparam int FU_ALU = 0;
    localparam int FU_LSU = 1;
    localparam int FU_CFU = 2;

    // --------------------
    // Micro-ops
    localparam uop_t ALU_ADD  = 5'd0;
    localparam uop_t ALU_SUB  = 5'd1;
    localparam uop_t ALU_AND  = 5'd2;
    localparam uop_t ALU_OR   = 5'd3;
    localparam uop_t ALU_XOR  = 5'd4;
    localparam uop_t ALU_SLT  = 5'd5;
    localparam uop_t ALU_SLTU = 5'd6;
    localparam uop_t ALU_SRA  = 5'd7;
    localparam uop_t ALU_SRL  = 5'd8;
    localparam uop_t ALU_SLL  = 5'd9;

    localparam uop_t CFU_BEQ  = 5'd1;
    localparam uop_t CFU_BNE  = 5'd2;
    localparam uop_t CFU_BLT  = 5'd3;
    localparam uop_t CFU_BGE  = 5'd4;
    localparam uop_t CFU_BLTU = 5'd5;
    localparam uop_t CFU_BGEU = 5'd6;
    localparam uop_t CFU_JALI = 5'd7;
    localparam uop_t CFU_JALR = 5'd8;

    // LSU micro-op is a bit field, width sits in bits 2:1
    localparam int         LSU_SIGNED = 0;
    localparam logic [1:0] LSU_BYTE   = 2'd0;
    localparam logic [1:0] LSU_HALF   = 2'd1;
    localparam logic [1:0] LSU_WORD   = 2'd2;
    localparam int         LSU_LOAD   = 3;
    localparam int         LSU_STORE  = 4;

    // --------------------
    // Major opcodes, low two bits included
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // Operand source bit positions
    localparam int OPRA_RS1    = 0;
    localparam int OPRA_PC     = 1;
    localparam int OPRB_RS2    = 2;
    localparam int OPRB_IMM    = 3;
    localparam int OPRC_RS2    = 4;
    localparam int OPRC_PCIM   = 5;
    localparam int OPRC_unused = 6;  // Reserved, always zero

    // Immediate formats
    localparam imm_fmt_t IMM_NONE  = 3'd0;
    localparam imm_fmt_t IMM_I     = 3'd1;
    localparam imm_fmt_t IMM_S     = 3'd2;
    localparam imm_fmt_t IMM_B     = 3'd3;
    localparam imm_fmt_t IMM_U     = 3'd4;
    localparam imm_fmt_t IMM_J     = 3'd5;
    localparam imm_fmt_t IMM_SHAMT = 3'd6;

    // Trap causes, carried in the rd field
    localparam reg_addr_t TRAP_IACCESS = 5'd1;
    localparam reg_addr_t TRAP_IOPCODE = 5'd2;

endpackage

/* instr_decoder.sv */
`timescale 1ns/1ns
// RV32I instruction decoder
// Classifies a 32-bit word as ALU, LSU or CFU work and picks the micro-op,
// register addresses, immediate format, operand sources and trap
module instr_decoder import decode_pkg::*; (
    input  word_t     s1_data,
    input  logic      s1_valid,
    input  logic      s1_error,
    output fu_t       fu,
    output uop_t      uop,
    output reg_addr_t rd,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output imm_fmt_t  imm_fmt,
    output opr_src_t  opr_src,
    output logic      trap,
    output logic      predict
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [1:0] lsu_width;
    logic       legal;     // Encoding recognised
    logic       has_rd;    // Writes a destination register
    logic       pred_dec;
    fu_t        fu_dec;

    assign opcode   = s1_data[6:0];
    assign funct3   = s1_data[14:12];
    assign funct7   = s1_data[31:25];
    assign rs1_addr = s1_data[19:15];
    assign rs2_addr = s1_data[24:20];

    // ALU op from funct3, alt picks SUB or SRA
    function automatic uop_t alu_uop(input logic [2:0] f3, input logic alt);
        uop_t u;
        case (f3)
            3'b000:  u = alt ? ALU_SUB : ALU_ADD;
            3'b001:  u = ALU_SLL;
            3'b010:  u = ALU_SLT;
            3'b011:  u = ALU_SLTU;
            3'b100:  u = ALU_XOR;
            3'b101:  u = alt ? ALU_SRA : ALU_SRL;
            3'b110:  u = ALU_OR;
            default: u = ALU_AND;
        endcase
        return u;
    endfunction

    always_comb begin
        case (funct3[1:0])
            2'b00:   lsu_width = LSU_BYTE;
            2'b01:   lsu_width = LSU_HALF;
            default: lsu_width = LSU_WORD;
        endcase
    end

    always_comb begin
        fu_dec   = '0;
        uop      = '0;
        imm_fmt  = IMM_NONE;
        opr_src  = '0;
        legal    = 1'b1;
        has_rd   = 1'b1;
        pred_dec = 1'b0;
        case (opcode)
            OP_LUI: begin
                fu_dec[FU_ALU]    = 1'b1;
                uop               = ALU_OR;   // Zero OR immediate
                imm_fmt           = IMM_U;
                opr_src[OPRB_IMM] = 1'b1;
            end
            OP_AUIPC: begin
                fu_dec[FU_ALU]    = 1'b1;
                uop               = ALU_ADD;
                imm_fmt           = IMM_U;
                opr_src[OPRA_PC]  = 1'b1;
                opr_src[OPRB_IMM] = 1'b1;
            end
            OP_REG: begin
                fu_dec[FU_ALU]    = 1'b1;
                uop               = alu_uop(funct3, funct7[5]);
                opr_src[OPRA_RS1] = 1'b1;
                opr_src[OPRB_RS2] = 1'b1;
                legal = funct7 == 7'b0000000 ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OP_IMM: begin
                fu_dec[FU_ALU]    = 1'b1;
                uop               = alu_uop(funct3, funct3 == 3'b101 && funct7[5]);
                opr_src[OPRA_RS1] = 1'b1;
                opr_src[OPRB_IMM] = 1'b1;
                imm_fmt           = IMM_I;
                if (funct3[1:0] == 2'b01) begin   // Shifts by immediate
                    imm_fmt = IMM_SHAMT;
                    legal   = funct7 == 7'b0000000 ||
                              (funct3 == 3'b101 && funct7 == 7'b0100000);
                end
            end
            OP_LOAD: begin
                fu_dec[FU_LSU]      = 1'b1;
                uop[LSU_LOAD]       = 1'b1;
                uop[LSU_SIGNED]     = !funct3[2] && funct3[1:0] != 2'b10;
                uop[2:1]            = lsu_width;
                imm_fmt             = IMM_I;
                opr_src[OPRA_RS1]   = 1'b1;
                opr_src[OPRB_IMM]   = 1'b1;
                legal = funct3 != 3'b011 && funct3[2:1] != 2'b11;
            end
            OP_STORE: begin
                fu_dec[FU_LSU]      = 1'b1;
                uop[LSU_STORE]      = 1'b1;
                uop[2:1]            = lsu_width;
                imm_fmt             = IMM_S;
                opr_src[OPRA_RS1]   = 1'b1;
                opr_src[OPRB_IMM]   = 1'b1;
                opr_src[OPRC_RS2]   = 1'b1;  // Store data
                has_rd              = 1'b0;
                legal = !funct3[2] && funct3[1:0] != 2'b11;
            end
            OP_BRANCH: begin
                fu_dec[FU_CFU]      = 1'b1;
                imm_fmt             = IMM_B;
                opr_src[OPRA_RS1]   = 1'b1;
                opr_src[OPRB_RS2]   = 1'b1;
                opr_src[OPRC_PCIM]  = 1'b1;
                has_rd              = 1'b0;
                pred_dec            = 1'b1;
                legal               = funct3[2:1] != 2'b01;
                case (funct3)
                    3'b000:  uop = CFU_BEQ;
                    3'b001:  uop = CFU_BNE;
                    3'b100:  uop = CFU_BLT;
                    3'b101:  uop = CFU_BGE;
                    3'b110:  uop = CFU_BLTU;
                    default: uop = CFU_BGEU;
                endcase
            end
            OP_JAL: begin
                fu_dec[FU_CFU]      = 1'b1;
                uop                 = CFU_JALI;
                imm_fmt             = IMM_J;
                opr_src[OPRC_PCIM]  = 1'b1;
                pred_dec            = 1'b1;
            end
            OP_JALR: begin
                fu_dec[FU_CFU]      = 1'b1;
                uop                 = CFU_JALR;
                imm_fmt             = IMM_I;
                opr_src[OPRA_RS1]   = 1'b1;
                opr_src[OPRB_IMM]   = 1'b1;
                legal               = funct3 == 3'b000;
            end
            default: legal = 1'b0;
        endcase
    end

    assign fu      = legal ? fu_dec : '0;
    assign predict = legal && pred_dec;
    assign trap    = s1_valid && (s1_error || !legal);

    // Illegal opcode wins over a fetch error
    assign rd = trap   ? (legal ? TRAP_IACCESS : TRAP_IOPCODE) :
                has_rd ? s1_data[11:7] : '0;

endmodule

/* operand_select.sv */
`timescale 1ns/1ns
// Operand selection for the decode stage
// Builds the sign-extended immediate and drives operands A, B and C,
// plus the PC-relative offset used by branches and JAL
module operand_select import decode_pkg::*; (
    input  word_t    s1_data,
    input  imm_fmt_t imm_fmt,
    input  opr_src_t opr_src,
    input  word_t    pc,
    input  word_t    rs1_rdata,
    input  word_t    rs2_rdata,
    output word_t    opr_a,
    output word_t    opr_b,
    output word_t    opr_c,
    output word_t    pc_offset
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    word_t imm_shamt;
    word_t imm;
    word_t pc_target;

    // --------------------
    // Immediate formats
    assign imm_i = {{20{s1_data[31]}}, s1_data[31:20]};
    assign imm_s = {{20{s1_data[31]}}, s1_data[31:25], s1_data[11:7]};
    assign imm_b = {{20{s1_data[31]}}, s1_data[7], s1_data[30:25],
                    s1_data[11:8], 1'b0};
    assign imm_u = {s1_data[31:12], 12'b0};
    assign imm_j = {{12{s1_data[31]}}, s1_data[19:12], s1_data[20],
                    s1_data[30:21], 1'b0};
    assign imm_shamt = {27'b0, s1_data[24:20]};

    always_comb begin
        case (imm_fmt)
            IMM_I:     imm = imm_i;
            IMM_S:     imm = imm_s;
            IMM_B:     imm = imm_b;
            IMM_U:     imm = imm_u;
            IMM_J:     imm = imm_j;
            IMM_SHAMT: imm = imm_shamt;
            default:   imm = '0;
        endcase
    end

    // Only B and J offsets are added to the PC
    assign pc_offset = (imm_fmt == IMM_B || imm_fmt == IMM_J) ? imm : '0;
    assign pc_target = pc + pc_offset;

    // --------------------
    // Operand muxes, unselected operands read as zero
    assign opr_a = {32{opr_src[OPRA_RS1]}}  & rs1_rdata |
                   {32{opr_src[OPRA_PC]}}   & pc;

    assign opr_b = {32{opr_src[OPRB_RS2]}}  & rs2_rdata |
                   {32{opr_src[OPRB_IMM]}}  & imm;

    assign opr_c = {32{opr_src[OPRC_RS2]}}  & rs2_rdata |
                   {32{opr_src[OPRC_PCIM]}} & pc_target;

endmodule

/* pc_predict.sv */
`timescale 1ns/1ns
// Decode program counter and static branch prediction
// Every branch and JAL is predicted taken and fetch is asked to redirect
module pc_predict import decode_pkg::*; #(
    parameter word_t PC_RESET = 32'h8000_0000
) (
    input  logic  g_clk,
    input  logic  g_resetn,
    input  logic  predict,
    input  logic  s1_valid,
    input  logic  s1_bubble,
    input  logic  stage_busy,
    input  logic  s1_cf_ack,
    input  word_t pc_offset,
    input  logic  cf_req,
    input  logic  cf_ack,
    input  word_t cf_target,
    input  logic  advance,
    output word_t pc,
    output logic  s1_cf_req,
    output word_t s1_cf_target,
    output logic  cf_stall
);

    word_t pc_next;

    assign s1_cf_req    = s1_valid && predict && !s1_bubble && !stage_busy;
    assign s1_cf_target = pc + pc_offset;
    assign cf_stall     = s1_cf_req && !s1_cf_ack;   // Wait for fetch ack

    assign pc_next = predict ? s1_cf_target : pc + 32'd4;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= PC_RESET;
        end else if (cf_req && cf_ack) begin
            pc <= cf_target;        // Later-stage redirect wins
        end else if (advance) begin
            pc <= pc_next;
        end
    end

endmodule

/* pipe_register.sv */
`timescale 1ns/1ns
// One-entry decode to execute stage register
// Holds its item while the next stage is busy, zeroes control on a bubble
module pipe_register import decode_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      flush,
    input  logic      in_valid,
    input  logic      bubble,
    input  reg_addr_t rd,
    input  uop_t      uop,
    input  fu_t       fu,
    input  logic      trap,
    input  word_t     opr_a,
    input  word_t     opr_b,
    input  word_t     opr_c,
    input  logic      out_busy,
    output logic      busy,
    output logic      s2_valid,
    output reg_addr_t s2_rd,
    output uop_t      s2_uop,
    output fu_t       s2_fu,
    output logic      s2_trap,
    output word_t     s2_opr_a,
    output word_t     s2_opr_b,
    output word_t     s2_opr_c
);

    assign busy = s2_valid && out_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || flush) begin
            s2_valid <= 1'b0;
        end else if (!busy) begin
            s2_valid <= in_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!busy) begin
            s2_rd    <= bubble ? '0 : rd;     // Bubble carries no work
            s2_uop   <= bubble ? '0 : uop;
            s2_fu    <= bubble ? '0 : fu;
            s2_trap  <= bubble ? 1'b0 : trap;
            s2_opr_a <= opr_a;
            s2_opr_b <= opr_b;
            s2_opr_c <= opr_c;
        end
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ns
// Decode stage of the RV32I core
// Decodes one instruction per accepted transfer, predicts branches and JAL
// taken and registers the result for the execute stage
module decode_stage import decode_pkg::*; #(
    parameter word_t PC_RESET = 32'h8000_0000
) (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      s1_valid,
    output logic      s1_busy,
    input  word_t     s1_data,
    input  logic      s1_error,      // Fetch error on this word
    input  logic      s1_flush,
    input  logic      s1_bubble,
    output reg_addr_t s1_rs1_addr,
    output reg_addr_t s1_rs2_addr,
    input  word_t     s1_rs1_rdata,
    input  word_t     s1_rs2_rdata,
    output logic      s1_cf_req,     // Predicted redirect to fetch
    output word_t     s1_cf_target,
    input  logic      s1_cf_ack,
    input  logic      cf_req,        // Redirect from a later stage
    input  word_t     cf_target,
    input  logic      cf_ack,
    output logic      s2_valid,
    input  logic      s2_busy,
    output reg_addr_t s2_rd,
    output word_t     s2_opr_a,
    output word_t     s2_opr_b,
    output word_t     s2_opr_c,
    output uop_t      s2_uop,
    output fu_t       s2_fu,
    output logic      s2_trap
);

    fu_t       dec_fu;
    uop_t      dec_uop;
    reg_addr_t dec_rd;
    imm_fmt_t  dec_imm_fmt;
    opr_src_t  dec_opr_src;
    logic      dec_trap;
    logic      dec_predict;
    word_t     opr_a;
    word_t     opr_b;
    word_t     opr_c;
    word_t     pc_offset;
    word_t     pc;
    logic      stage_busy;
    logic      cf_stall;
    logic      advance;
    logic      in_valid;

    // --------------------
    // Handshake
    assign s1_busy  = stage_busy || s1_bubble || cf_stall;
    assign advance  = s1_valid && !s1_busy;
    assign in_valid = (s1_valid || s1_bubble) && !cf_stall;

    instr_decoder u_decoder (
        .s1_data  (s1_data),
        .s1_valid (s1_valid),
        .s1_error (s1_error),
        .fu       (dec_fu),
        .uop      (dec_uop),
        .rd       (dec_rd),
        .rs1_addr (s1_rs1_addr),
        .rs2_addr (s1_rs2_addr),
        .imm_fmt  (dec_imm_fmt),
        .opr_src  (dec_opr_src),
        .trap     (dec_trap),
        .predict  (dec_predict)
    );

    operand_select u_operands (
        .s1_data   (s1_data),
        .imm_fmt   (dec_imm_fmt),
        .opr_src   (dec_opr_src),
        .pc        (pc),
        .rs1_rdata (s1_rs1_rdata),
        .rs2_rdata (s1_rs2_rdata),
        .opr_a     (opr_a),
        .opr_b     (opr_b),
        .opr_c     (opr_c),
        .pc_offset (pc_offset)
    );

    pc_predict #(
        .PC_RESET (PC_RESET)
    ) u_pc (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .predict      (dec_predict),
        .s1_valid     (s1_valid),
        .s1_bubble    (s1_bubble),
        .stage_busy   (stage_busy),
        .s1_cf_ack    (s1_cf_ack),
        .pc_offset    (pc_offset),
        .cf_req       (cf_req),
        .cf_ack       (cf_ack),
        .cf_target    (cf_target),
        .advance      (advance),
        .pc           (pc),
        .s1_cf_req    (s1_cf_req),
        .s1_cf_target (s1_cf_target),
        .cf_stall     (cf_stall)
    );

    pipe_register u_pipe (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .flush    (s1_flush),
        .in_valid (in_valid),
        .bubble   (s1_bubble),
        .rd       (dec_rd),
        .uop      (dec_uop),
        .fu       (dec_fu),
        .trap     (dec_trap),
        .opr_a    (opr_a),
        .opr_b    (opr_b),
        .opr_c    (opr_c),
        .out_busy (s2_busy),
        .busy     (stage_busy),
        .s2_valid (s2_valid),
        .s2_rd    (s2_rd),
        .s2_uop   (s2_uop),
        .s2_fu    (s2_fu),
        .s2_trap  (s2_trap),
        .s2_opr_a (s2_opr_a),
        .s2_opr_b (s2_opr_b),
        .s2_opr_c (s2_opr_c)
    );

endmodule

/* decode_chk.sv */
`timescale 1ns/1ns
// Protocol assertions for the decode stage, bound into decode_stage
module decode_chk import decode_pkg::*; (
    input logic      g_clk,
    input logic      g_resetn,
    input logic      s1_busy,
    input logic      s1_flush,
    input logic      s1_cf_req,
    input logic      s1_cf_ack,
    input logic      s2_valid,
    input logic      s2_busy,
    input reg_addr_t s2_rd,
    input uop_t      s2_uop,
    input fu_t       s2_fu,
    input logic      s2_trap,
    input word_t     s2_opr_a,
    input word_t     s2_opr_b,
    input word_t     s2_opr_c
);

    // --------------------
    reset_clears_valid: assert property (@(posedge g_clk) !g_resetn |=> !s2_valid)
        else $error("s2_valid high after reset");

    // Held item must not change under back-pressure
    output_held: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_valid && s2_busy && !s1_flush |=>
            s2_valid && $stable(s2_rd) && $stable(s2_uop) && $stable(s2_fu) &&
            $stable(s2_trap) && $stable(s2_opr_a) && $stable(s2_opr_b) &&
            $stable(s2_opr_c))
        else $error("s2 outputs changed while held");

    fu_onehot: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_valid |-> $onehot0(s2_fu))
        else $error("s2_fu has more than one bit set");

    // Stalled prediction keeps the instruction out of the stage register
    stall_busy: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s1_cf_req && !s1_cf_ack |=> $past(s1_busy) && !s2_valid)
        else $error("prediction pending without s1_busy or with an item issued");

endmodule

bind decode_stage decode_chk u_chk (
    .g_clk     (g_clk),
    .g_resetn  (g_resetn),
    .s1_busy   (s1_busy),
    .s1_flush  (s1_flush),
    .s1_cf_req (s1_cf_req),
    .s1_cf_ack (s1_cf_ack),
    .s2_valid  (s2_valid),
    .s2_busy   (s2_busy),
    .s2_rd     (s2_rd),
    .s2_uop    (s2_uop),
    .s2_fu     (s2_fu),
    .s2_trap   (s2_trap),
    .s2_opr_a  (s2_opr_a),
    .s2_opr_b  (s2_opr_b),
    .s2_opr_c  (s2_opr_c)
);

/* tb_decode.sv */
`timescale 1ns/1ns
// Testbench for the RV32I decode stage
// Directed tests for ALU, LSU and CFU decode, traps, back-pressure,
// bubbles, flush and PC redirect, checked against a small reference model
module tb_decode;
    import decode_pkg::*;

    localparam int   CYCLE_LIMIT = 2000;           // Tests need well under 200 cycles
    localparam fu_t  ALU_SEL = 5'd1 << FU_ALU;
    localparam fu_t  LSU_SEL = 5'd1 << FU_LSU;
    localparam fu_t  CFU_SEL = 5'd1 << FU_CFU;

    logic g_clk, g_resetn;
    logic s1_valid, s1_busy, s1_error, s1_flush, s1_bubble;
    word_t s1_data, s1_rs1_rdata, s1_rs2_rdata, s1_cf_target, cf_target;
    reg_addr_t s1_rs1_addr, s1_rs2_addr, s2_rd;
    logic s1_cf_req, s1_cf_ack, cf_req, cf_ack, s2_valid, s2_busy, s2_trap;
    word_t s2_opr_a, s2_opr_b, s2_opr_c;
    uop_t s2_uop;
    fu_t s2_fu;

    word_t model_pc = 32'h8000_0000;  // PC the DUT should hold
    word_t acc_pc;                    // PC of the last accepted instruction
    word_t rs1_val, rs2_val;
    word_t lcg_state = 32'h82b6;
    int    cycle_count = 0;

    decode_stage DUT (.*);

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;
    end

    always @(posedge g_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the DUT did not finish the tests within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $fatal(1, "run aborted");
        end
    end

    // --------------------
    // Helpers
    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                    input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    // Expected LSU micro-op from its fields
    function automatic uop_t lsu_op(input logic ld, input logic sign, input logic [1:0] width);
        uop_t u;
        u = '0;
        u[LSU_LOAD]   = ld;
        u[LSU_STORE]  = !ld;
        u[LSU_SIGNED] = sign;
        u[2:1]        = width;
        return u;
    endfunction

    task automatic check_eq(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge g_clk);
        #5;
    endtask

    // Present one instruction and wait until the stage accepts it
    task automatic issue(input word_t instr, input logic err, input logic pred,
                         input word_t offset, input int ack_wait);
        int i;
        s1_valid = 1'b1;
        s1_data  = instr;
        s1_error = err;
        rs1_val  = next_rand();
        rs2_val  = next_rand();
        s1_rs1_rdata = rs1_val;
        s1_rs2_rdata = rs2_val;
        #1;
        check_eq(32'(s1_rs1_addr), 32'(instr[19:15]), "s1_rs1_addr");
        check_eq(32'(s1_rs2_addr), 32'(instr[24:20]), "s1_rs2_addr");
        check_eq(32'(s1_cf_req), 32'(pred), "s1_cf_req");
        if (pred) begin
            check_eq(s1_cf_target, model_pc + offset, "s1_cf_target");
            for (i = 0; i < ack_wait; i++) begin
                check_eq(32'(s1_busy), 32'd1, "s1_busy before ack");
                next_cycle();
            end
            s1_cf_ack = 1'b1;
            #1;
        end
        while (s1_busy) next_cycle();   // Bounded by the cycle counter
        next_cycle();
        s1_valid  = 1'b0;
        s1_error  = 1'b0;
        s1_cf_ack = 1'b0;
        acc_pc    = model_pc;
        model_pc  = pred ? model_pc + offset : model_pc + 32'd4;
    endtask

    task automatic expect_out(input fu_t fu, input uop_t uop, input reg_addr_t rd,
                              input logic trap, input word_t a, input word_t b,
                              input word_t c);
        check_eq(32'(s2_valid), 32'd1, "s2_valid");
        check_eq(32'(s2_fu), 32'(fu), "s2_fu");
        check_eq(32'(s2_uop), 32'(uop), "s2_uop");
        check_eq(32'(s2_rd), 32'(rd), "s2_rd");
        check_eq(32'(s2_trap), 32'(trap), "s2_trap");
        check_eq(s2_opr_a, a, "s2_opr_a");
        check_eq(s2_opr_b, b, "s2_opr_b");
        check_eq(s2_opr_c, c, "s2_opr_c");
    endtask

    // --------------------
    // Tests
    task automatic test_alu();
        issue(enc_u(20'h12345, 5'd10, OP_AUIPC), 1'b0, 1'b0, 32'd0, 0);
        check_eq(s2_opr_a, 32'h8000_0000, "pc after reset");
        expect_out(ALU_SEL, ALU_ADD, 5'd10, 1'b0, acc_pc, 32'h1234_5000, 32'd0);
        issue(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 1'b0, 1'b0, 32'd0, 0);
        expect_out(ALU_SEL, ALU_ADD, 5'd3, 1'b0, rs1_val, rs2_val, 32'd0);
        issue(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd4), 1'b0, 1'b0, 32'd0, 0);
        expect_out(ALU_SEL, ALU_SUB, 5'd4, 1'b0, rs1_val, rs2_val, 32'd0);
        issue(enc_r(7'h20, 5'd7, 5'd8, 3'd5, 5'd5), 1'b0, 1'b0, 32'd0, 0);
        expect_out(ALU_SEL, ALU_SRA, 5'd5, 1'b0, rs1_val, rs2_val, 32'd0);
        issue(enc_r(7'h00, 5'd9, 5'd3, 3'd3, 5'd6), 1'b0, 1'b0, 32'd0, 0);
        expect_out(ALU_SEL, ALU_SLTU, 5'd6, 1'b0, rs1_val, rs2_val, 32'd0);
        issue(enc_i(12'hff9, 5'd6, 3'd0, 5'd5, OP_IMM), 1'b0, 1'b0, 32'd0, 0);
        expect_out(ALU_SEL, ALU_ADD, 5'd5, 1'b0, rs1_val, 32'hffff_fff9, 32'd0);
        issue(enc_i(12'h7ff, 5'd6, 3'd4, 5'd7, OP_IMM), 1'b0, 1'b0, 32'd0, 0);
        expect_out(ALU_SEL, ALU_XOR, 5'd7, 1'b0, rs1_val, 32'h0000_07ff, 32'd0);
        issue(enc_i(12'h409, 5'd6, 3'd5, 5'd8, OP_IMM), 1'b0, 1'b0, 32'd0, 0);
        expect_out(ALU_SEL, ALU_SRA, 5'd8, 1'b0, rs1_val, 32'd9, 32'd0);
        issue(enc_u(20'habcde, 5'd9, OP_LUI), 1'b0, 1'b0, 32'd0, 0);
        expect_out(ALU_SEL, ALU_OR, 5'd9, 1'b0, 32'd0, 32'habcd_e000, 32'd0);
    endtask

    task automatic test_lsu();
        issue(enc_i(12'hffc, 5'd1, 3'd2, 5'd9, OP_LOAD), 1'b0, 1'b0, 32'd0, 0);
        expect_out(LSU_SEL, lsu_op(1'b1, 1'b0, LSU_WORD), 5'd9, 1'b0, rs1_val,
                   32'hffff_fffc, 32'd0);
        issue(enc_i(12'd3, 5'd2, 3'd0, 5'd11, OP_LOAD), 1'b0, 1'b0, 32'd0, 0);
        expect_out(LSU_SEL, lsu_op(1'b1, 1'b1, LSU_BYTE), 5'd11, 1'b0, rs1_val, 32'd3, 32'd0);
        issue(enc_i(12'd6, 5'd2, 3'd5, 5'd12, OP_LOAD), 1'b0, 1'b0, 32'd0, 0);
        expect_out(LSU_SEL, lsu_op(1'b1, 1'b0, LSU_HALF), 5'd12, 1'b0, rs1_val, 32'd6, 32'd0);
        issue(enc_s(12'd20, 5'd2, 5'd1, 3'd2), 1'b0, 1'b0, 32'd0, 0);
        expect_out(LSU_SEL, lsu_op(1'b0, 1'b0, LSU_WORD), 5'd0, 1'b0, rs1_val, 32'd20, rs2_val);
        issue(enc_s(12'hf9c, 5'd4, 5'd3, 3'd0), 1'b0, 1'b0, 32'd0, 0);
        expect_out(LSU_SEL, lsu_op(1'b0, 1'b0, LSU_BYTE), 5'd0, 1'b0, rs1_val,
                   32'hffff_ff9c, rs2_val);
    endtask

    task automatic test_branch();
        issue(enc_b(13'd16, 5'd2, 5'd1, 3'd0), 1'b0, 1'b1, 32'd16, 3);
        expect_out(CFU_SEL, CFU_BEQ, 5'd0, 1'b0, rs1_val, rs2_val, acc_pc + 32'd16);
        issue(enc_b(13'h1ff8, 5'd4, 5'd3, 3'd6), 1'b0, 1'b1, 32'hffff_fff8, 0);
        expect_out(CFU_SEL, CFU_BLTU, 5'd0, 1'b0, rs1_val, rs2_val, acc_pc - 32'd8);
        issue(enc_j(21'd2048, 5'd1), 1'b0, 1'b1, 32'd2048, 1);
        expect_out(CFU_SEL, CFU_JALI, 5'd1, 1'b0, 32'd0, 32'd0, acc_pc + 32'd2048);
        issue(enc_i(12'd8, 5'd5, 3'd0, 5'd1, OP_JALR), 1'b0, 1'b0, 32'd0, 0);
        expect_out(CFU_SEL, CFU_JALR, 5'd1, 1'b0, rs1_val, 32'd8, 32'd0);
        issue(enc_u(20'h0, 5'd2, OP_AUIPC), 1'b0, 1'b0, 32'd0, 0);  // Shows the taken PC
        expect_out(ALU_SEL, ALU_ADD, 5'd2, 1'b0, acc_pc, 32'd0, 32'd0);
    endtask

    task automatic test_trap();
        issue(32'h0000_007f, 1'b0, 1'b0, 32'd0, 0);
        expect_out(5'd0, 5'd0, TRAP_IOPCODE, 1'b1, 32'd0, 32'd0, 32'd0);
        issue(32'h0000_040b, 1'b1, 1'b0, 32'd0, 0);   // Illegal beats fetch error
        expect_out(5'd0, 5'd0, TRAP_IOPCODE, 1'b1, 32'd0, 32'd0, 32'd0);
        issue(enc_i(12'd1, 5'd0, 3'd0, 5'd5, OP_IMM), 1'b1, 1'b0, 32'd0, 0);
        expect_out(ALU_SEL, ALU_ADD, TRAP_IACCESS, 1'b1, rs1_val, 32'd1, 32'd0);
    endtask

    task automatic test_flow();
        int i;
        issue(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd10), 1'b0, 1'b0, 32'd0, 0);
        s2_busy  = 1'b1;
        s1_valid = 1'b1;
        s1_data  = enc_i(12'd5, 5'd1, 3'd0, 5'd11, OP_IMM);
        for (i = 0; i < 4; i++) begin
            #1;
            check_eq(32'(s1_busy), 32'd1, "s1_busy under back-pressure");
            next_cycle();
            expect_out(ALU_SEL, ALU_OR, 5'd10, 1'b0, rs1_val, rs2_val, 32'd0);
        end
        s2_busy = 1'b0;
        issue(enc_i(12'd5, 5'd1, 3'd0, 5'd11, OP_IMM), 1'b0, 1'b0, 32'd0, 0);
        expect_out(ALU_SEL, ALU_ADD, 5'd11, 1'b0, rs1_val, 32'd5, 32'd0);
        s1_bubble = 1'b1;
        #1;
        check_eq(32'(s1_busy), 32'd1, "s1_busy on bubble");
        next_cycle();
        s1_bubble = 1'b0;
        check_eq(32'(s2_valid), 32'd1, "bubble s2_valid");
        check_eq(32'({s2_rd, s2_uop, s2_fu, s2_trap}), 32'd0, "bubble control fields");
        issue(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd12), 1'b0, 1'b0, 32'd0, 0);
        s2_busy  = 1'b1;
        s1_flush = 1'b1;
        next_cycle();
        check_eq(32'(s2_valid), 32'd0, "s2_valid after flush");
        s1_flush = 1'b0;
        s2_busy  = 1'b0;
    endtask

    task automatic test_redirect();
        cf_req    = 1'b1;
        cf_ack    = 1'b1;
        cf_target = 32'h0000_4000;
        next_cycle();
        cf_req   = 1'b0;
        cf_ack   = 1'b0;
        model_pc = 32'h0000_4000;
        issue(enc_u(20'h00001, 5'd3, OP_AUIPC), 1'b0, 1'b0, 32'd0, 0);
        expect_out(ALU_SEL, ALU_ADD, 5'd3, 1'b0, 32'h0000_4000, 32'h0000_1000, 32'd0);
    endtask

    // --------------------
    // Main sequence
    initial begin
        g_resetn  = 1'b0;
        s1_valid  = 1'b0;
        s1_data   = '0;
        s1_error  = 1'b0;
        s1_flush  = 1'b0;
        s1_bubble = 1'b0;
        s1_rs1_rdata = '0;
        s1_rs2_rdata = '0;
        s1_cf_ack = 1'b0;
        cf_req    = 1'b0;
        cf_target = '0;
        cf_ack    = 1'b0;
        s2_busy   = 1'b0;
        repeat (16) @(posedge g_clk);
        #5;
        g_resetn = 1'b1;
        check_eq(32'(s2_valid), 32'd0, "s2_valid after reset");
        check_eq(32'(s1_cf_req), 32'd0, "s1_cf_req after reset");
        test_alu();
        test_lsu();
        test_branch();
        test_trap();
        test_flow();
        test_redirect();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* src.f */
decode_pkg.sv
instr_decoder.sv
operand_select.sv
pc_predict.sv
pipe_register.sv
decode_stage.sv
decode_chk.sv
tb_decode.sv

/* run.sh */
#!/bin/sh
# Compile and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_decode -f src.f -o sim_decode || exit 1
out=$(./obj_dir/sim_decode)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1
